// ==== rtl/tcp_rx_config.svh ====
`ifndef TCP_RX_CONFIG_SVH
`define TCP_RX_CONFIG_SVH

// payload FIFO entries as a power of two
`define TCP_RX_FIFO_DEPTH 16

// must match log2 of the depth
`define TCP_RX_FIFO_AW 4

`endif

// ==== rtl/tcp_rx_pkg.sv ====
`default_nettype none

package tcp_rx_pkg;

typedef logic [7:0]  byte_t;
typedef logic [15:0] port_t;
typedef logic [31:0] ipv4_addr_t;
typedef logic [15:0] ip_len_t;
typedef logic [15:0] drop_count_t;

// only the IP fields this path needs
typedef struct packed {
    ipv4_addr_t src_ip;
    ip_len_t    length;
} ip_hdr_t;

typedef struct packed {
    byte_t data;
    logic  last;
} beat_t;

typedef struct packed {
    port_t      dest_port;
    port_t      src_port;
    ipv4_addr_t src_ip;
} pkt_meta_t;

typedef enum logic [1:0] {
    PORTS,
    PASSTHROUGH,
    DISCARD
} decap_state_t;

typedef enum logic [1:0] {
    IDLE,
    FORWARD,
    DROP
} filter_state_t;

endpackage

`default_nettype wire

// ==== rtl/skid_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module skid_buffer #(
    parameter int WIDTH = 8
) (
    input  wire              i_clk,
    input  wire              i_rst,

    input  wire              i_valid,
    input  wire [WIDTH-1:0]  i_data,
    output logic             o_ready,

    output logic             o_valid,
    output logic [WIDTH-1:0] o_data,
    input  wire              i_ready
);

logic             spare_valid;
logic [WIDTH-1:0] spare_data;
logic             in_fire;
logic             load;

// ready comes straight from a flop
assign o_ready = !spare_valid;
assign in_fire = i_valid && o_ready;

// main register may take new data
assign load = !o_valid || i_ready;

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        o_valid     <= 1'b0;
        spare_valid <= 1'b0;
    end else if (load) begin
        o_valid     <= spare_valid || in_fire;
        spare_valid <= 1'b0;
    end else if (in_fire) begin
        spare_valid <= 1'b1;
    end
end

always_ff @(posedge i_clk) begin
    if (load) begin
        o_data <= spare_valid ? spare_data : i_data;
    end
    // stalled output, park the incoming word
    if (!load && in_fire) begin
        spare_data <= i_data;
    end
end

assert property (@(posedge i_clk) disable iff (i_rst)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

`default_nettype wire

// ==== rtl/tcp_dest_decap.sv ====
`timescale 1ns/100ps
`default_nettype none

module tcp_dest_decap (
    input  wire                        i_clk,
    input  wire                        i_rst,

    input  wire                        i_hdr_valid,
    input  wire tcp_rx_pkg::ip_hdr_t   i_hdr,

    input  wire                        i_in_valid,
    input  wire tcp_rx_pkg::beat_t     i_in,
    output logic                       o_in_ready,

    output logic                       o_meta_valid,
    output tcp_rx_pkg::pkt_meta_t      o_meta,
    input  wire                        i_meta_ready,

    output logic                       o_out_valid,
    output tcp_rx_pkg::beat_t          o_out,
    input  wire                        i_out_ready
);

import tcp_rx_pkg::*;

decap_state_t state;
logic [1:0]   byte_cnt;
logic [23:0]  port_sr;
ipv4_addr_t   src_ip_q;
logic         run_q;
logic         in_fire;
logic         port_fire;

always_comb begin
    case (state)
        // hold off while the previous metadata is still waiting
        PORTS:       o_in_ready = run_q && !o_meta_valid;
        PASSTHROUGH: o_in_ready = i_out_ready || !o_out_valid;
        default:     o_in_ready = 1'b0;
    endcase
end

assign in_fire   = i_in_valid && o_in_ready;
assign port_fire = in_fire && (state == PORTS);

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        state        <= PORTS;
        byte_cnt     <= 2'd0;
        run_q        <= 1'b0;
        o_meta_valid <= 1'b0;
        o_out_valid  <= 1'b0;
    end else begin
        run_q <= 1'b1;
        if (i_meta_ready) begin
            o_meta_valid <= 1'b0;
        end
        if (i_out_ready) begin
            o_out_valid <= 1'b0;
        end
        case (state)
            PORTS: begin
                if (in_fire) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    // packet ended inside the port bytes
                    if (i_in.last) begin
                        state    <= DISCARD;
                        byte_cnt <= 2'd0;
                    end else if (byte_cnt == 2'd3) begin
                        o_meta_valid <= 1'b1;
                        state        <= PASSTHROUGH;
                    end
                end
            end
            PASSTHROUGH: begin
                if (in_fire) begin
                    o_out_valid <= 1'b1;
                    if (i_in.last) begin
                        state <= PORTS;
                    end
                end
            end
            default: state <= PORTS;
        endcase
    end
end

always_ff @(posedge i_clk) begin
    if (i_hdr_valid) begin
        src_ip_q <= i_hdr.src_ip;
    end
    if (port_fire) begin
        port_sr <= {port_sr[15:0], i_in.data};
    end
    // network order, src port first
    if (port_fire && byte_cnt == 2'd3) begin
        o_meta.src_port  <= port_sr[23:8];
        o_meta.dest_port <= {port_sr[7:0], i_in.data};
        o_meta.src_ip    <= src_ip_q;
    end
    if (in_fire && state == PASSTHROUGH) begin
        o_out <= i_in;
    end
end

assert property (@(posedge i_clk) disable iff (i_rst)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out));

assert property (@(posedge i_clk) disable iff (i_rst)
    o_meta_valid && !i_meta_ready |=> o_meta_valid && $stable(o_meta));

endmodule

`default_nettype wire

// ==== rtl/payload_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tcp_rx_config.svh"

module payload_fifo (
    input  wire                    i_clk,
    input  wire                    i_rst,

    input  wire                    i_valid,
    input  wire tcp_rx_pkg::beat_t i_data,
    output logic                   o_ready,

    output logic                   o_valid,
    output tcp_rx_pkg::beat_t      o_data,
    input  wire                    i_ready
);

import tcp_rx_pkg::*;

localparam int DEPTH = `TCP_RX_FIFO_DEPTH;
localparam int AW    = `TCP_RX_FIFO_AW;
localparam logic [AW:0] FULL_COUNT = (AW+1)'(DEPTH);

beat_t         mem [DEPTH];
logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [AW:0]   count;
logic          wr_fire;
logic          load;
logic          mem_rd;
logic          mem_wr;

assign o_ready = (count != FULL_COUNT);
assign wr_fire = i_valid && o_ready;
assign load    = !o_valid || i_ready;
assign mem_rd  = load && (count != '0);

// the beat bypasses memory when the FIFO is empty and the output is free
assign mem_wr  = wr_fire && !(load && count == '0);

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        wr_ptr  <= '0;
        rd_ptr  <= '0;
        count   <= '0;
        o_valid <= 1'b0;
    end else begin
        if (mem_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (mem_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({mem_wr, mem_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
        if (load) begin
            o_valid <= mem_rd || wr_fire;
        end
    end
end

always_ff @(posedge i_clk) begin
    if (mem_wr) begin
        mem[wr_ptr] <= i_data;
    end
    if (mem_rd) begin
        o_data <= mem[rd_ptr];
    end else if (load && wr_fire) begin
        o_data <= i_data;
    end
end

// a write when full or a read when empty would push the count out of range
assert property (@(posedge i_clk) disable iff (i_rst) count <= FULL_COUNT);

// beats held in memory always sit behind a valid output register
assert property (@(posedge i_clk) disable iff (i_rst) count != '0 |-> o_valid);

endmodule

`default_nettype wire

// ==== rtl/port_filter.sv ====
`timescale 1ns/100ps
`default_nettype none

module port_filter (
    input  wire                          i_clk,
    input  wire                          i_rst,

    input  wire tcp_rx_pkg::port_t       i_listen_port,

    input  wire                          i_meta_valid,
    input  wire tcp_rx_pkg::pkt_meta_t   i_meta,
    output logic                         o_meta_ready,

    input  wire                          i_in_valid,
    input  wire tcp_rx_pkg::beat_t       i_in,
    output logic                         o_in_ready,

    output logic                         o_out_valid,
    output tcp_rx_pkg::beat_t            o_out,
    input  wire                          i_out_ready,

    output logic                         o_meta_out_valid,
    output tcp_rx_pkg::pkt_meta_t        o_meta_out,
    output tcp_rx_pkg::drop_count_t      o_drop_count
);

import tcp_rx_pkg::*;

filter_state_t state;
pkt_meta_t     meta_q;
logic          first_q;
logic          meta_fire;
logic          in_fire;
logic          match;

assign o_meta_ready = (state == IDLE);
assign meta_fire    = i_meta_valid && o_meta_ready;
assign match        = (i_meta.dest_port == i_listen_port);

always_comb begin
    o_out_valid = 1'b0;
    o_in_ready  = 1'b0;
    case (state)
        FORWARD: begin
            o_out_valid = i_in_valid;
            o_in_ready  = i_out_ready;
        end
        // sink everything
        DROP:    o_in_ready = 1'b1;
        default: o_in_ready = 1'b0;
    endcase
end

assign o_out            = i_in;
assign in_fire          = i_in_valid && o_in_ready;
assign o_meta_out_valid = (state == FORWARD) && first_q && in_fire;
assign o_meta_out       = meta_q;

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        state        <= IDLE;
        first_q      <= 1'b0;
        o_drop_count <= '0;
    end else begin
        case (state)
            IDLE: begin
                if (meta_fire && match) begin
                    state   <= FORWARD;
                    first_q <= 1'b1;
                end else if (meta_fire) begin
                    state <= DROP;
                    // saturate
                    if (o_drop_count != '1) begin
                        o_drop_count <= o_drop_count + 1'b1;
                    end
                end
            end
            FORWARD: begin
                if (in_fire) begin
                    first_q <= 1'b0;
                    if (i_in.last) begin
                        state <= IDLE;
                    end
                end
            end
            DROP: begin
                if (in_fire && i_in.last) begin
                    state <= IDLE;
                end
            end
            default: state <= IDLE;
        endcase
    end
end

always_ff @(posedge i_clk) begin
    if (meta_fire) begin
        meta_q <= i_meta;
    end
end

// a forwarded packet always carries the listening port
assert property (@(posedge i_clk) disable iff (i_rst)
    o_meta_out_valid |-> o_meta_out.dest_port == i_listen_port);

endmodule

`default_nettype wire

// ==== rtl/tcp_rx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tcp_rx_top (
    input  wire                          i_clk,
    input  wire                          i_rst,

    input  wire                          i_hdr_valid,
    input  wire tcp_rx_pkg::ip_hdr_t     i_hdr,

    input  wire                          i_in_valid,
    input  wire tcp_rx_pkg::beat_t       i_in,
    output logic                         o_in_ready,

    input  wire tcp_rx_pkg::port_t       i_listen_port,

    output logic                         o_out_valid,
    output tcp_rx_pkg::beat_t            o_out,
    input  wire                          i_out_ready,

    output logic                         o_meta_valid,
    output tcp_rx_pkg::pkt_meta_t        o_meta,
    output tcp_rx_pkg::drop_count_t      o_drop_count
);

import tcp_rx_pkg::*;

// decapsulator side
logic      dec_meta_valid;
pkt_meta_t dec_meta;
logic      dec_meta_ready;
logic      dec_out_valid;
beat_t     dec_out;
logic      dec_out_ready;

// filter side
logic      flt_meta_valid;
pkt_meta_t flt_meta;
logic      flt_meta_ready;
logic      flt_in_valid;
beat_t     flt_in;
logic      flt_in_ready;

tcp_dest_decap u_decap (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_hdr_valid    (i_hdr_valid),
    .i_hdr          (i_hdr),
    .i_in_valid     (i_in_valid),
    .i_in           (i_in),
    .o_in_ready     (o_in_ready),
    .o_meta_valid   (dec_meta_valid),
    .o_meta         (dec_meta),
    .i_meta_ready   (dec_meta_ready),
    .o_out_valid    (dec_out_valid),
    .o_out          (dec_out),
    .i_out_ready    (dec_out_ready)
);

skid_buffer #(
    .WIDTH          ($bits(pkt_meta_t))
) u_meta_skid (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (dec_meta_valid),
    .i_data         (dec_meta),
    .o_ready        (dec_meta_ready),
    .o_valid        (flt_meta_valid),
    .o_data         (flt_meta),
    .i_ready        (flt_meta_ready)
);

payload_fifo u_fifo (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (dec_out_valid),
    .i_data         (dec_out),
    .o_ready        (dec_out_ready),
    .o_valid        (flt_in_valid),
    .o_data         (flt_in),
    .i_ready        (flt_in_ready)
);

port_filter u_filter (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_listen_port    (i_listen_port),
    .i_meta_valid     (flt_meta_valid),
    .i_meta           (flt_meta),
    .o_meta_ready     (flt_meta_ready),
    .i_in_valid       (flt_in_valid),
    .i_in             (flt_in),
    .o_in_ready       (flt_in_ready),
    .o_out_valid      (o_out_valid),
    .o_out            (o_out),
    .i_out_ready      (i_out_ready),
    .o_meta_out_valid (o_meta_valid),
    .o_meta_out       (o_meta),
    .o_drop_count     (o_drop_count)
);

endmodule

`default_nettype wire

// ==== bench/tb_tcp_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_tcp_rx;

import tcp_rx_pkg::*;

localparam int    SEED        = 38887;
localparam port_t LISTEN_PORT = 16'h1f90;
localparam int    NUM_PKTS    = 200;
localparam int    MAX_LEN     = 24;

logic        i_clk;
logic        i_rst;
logic        i_hdr_valid;
ip_hdr_t     i_hdr;
logic        i_in_valid;
beat_t       i_in;
logic        o_in_ready;
port_t       i_listen_port;
logic        o_out_valid;
beat_t       o_out;
logic        i_out_ready;
logic        o_meta_valid;
pkt_meta_t   o_meta;
drop_count_t o_drop_count;

integer seed;
integer ready_seed;

byte_t      pkt_data [NUM_PKTS][MAX_LEN];
int         pkt_len [NUM_PKTS];
ipv4_addr_t pkt_ip [NUM_PKTS];
int         total_bytes;
int         ref_drops;

beat_t     exp_beats [$];
int        exp_beat_pkt [$];
pkt_meta_t exp_metas [$];
int        exp_meta_pkt [$];
int        exp_meta_drops [$];

int cycle_count;
int cycle_limit;
int reset_checks;
int reset_errs;
int beat_checks;
int beat_errs;
int meta_checks;
int meta_errs;
int drop_checks;
int drop_errs;

beat_t     mon_beat;
int        mon_pkt;
pkt_meta_t mon_meta;
int        mon_drops;

tcp_rx_top DUT (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_hdr_valid   (i_hdr_valid),
    .i_hdr         (i_hdr),
    .i_in_valid    (i_in_valid),
    .i_in          (i_in),
    .o_in_ready    (o_in_ready),
    .i_listen_port (i_listen_port),
    .o_out_valid   (o_out_valid),
    .o_out         (o_out),
    .i_out_ready   (i_out_ready),
    .o_meta_valid  (o_meta_valid),
    .o_meta        (o_meta),
    .o_drop_count  (o_drop_count)
);

always #10 i_clk = ~i_clk;

// expected beats and metadata of one packet, straight from the port layout
function automatic void predict_packet(input int idx);
    port_t     src;
    port_t     dst;
    pkt_meta_t meta;
    beat_t     b;
    int        i;
    // ends inside the port bytes, nothing comes out
    if (pkt_len[idx] <= 4) begin
        return;
    end
    src = {pkt_data[idx][0], pkt_data[idx][1]};
    dst = {pkt_data[idx][2], pkt_data[idx][3]};
    if (dst != LISTEN_PORT) begin
        ref_drops++;
        return;
    end
    meta.dest_port = dst;
    meta.src_port  = src;
    meta.src_ip    = pkt_ip[idx];
    exp_metas.push_back(meta);
    exp_meta_pkt.push_back(idx);
    exp_meta_drops.push_back(ref_drops);
    for (i = 4; i < pkt_len[idx]; i++) begin
        b.data = pkt_data[idx][i];
        b.last = (i == pkt_len[idx] - 1);
        exp_beats.push_back(b);
        exp_beat_pkt.push_back(idx);
    end
endfunction

task automatic build_packets;
    int    p;
    int    i;
    port_t src;
    port_t dst;
    total_bytes = 0;
    for (p = 0; p < NUM_PKTS; p++) begin
        pkt_len[p] = 1 + int'($unsigned($random(seed)) % MAX_LEN);
        src = 16'($random(seed));
        dst = 16'($random(seed));
        if ($random(seed) & 1) begin
            dst = LISTEN_PORT;
        end else if (dst == LISTEN_PORT) begin
            dst = dst ^ 16'h0001;
        end
        pkt_ip[p] = $random(seed);
        // a few fixed corners, the final packet flushes everything before it
        if (p == 0) begin
            pkt_len[p] = 4;
        end
        if (p == 1) begin
            pkt_len[p] = 5;
            dst = LISTEN_PORT;
        end
        if (p == NUM_PKTS - 1) begin
            pkt_len[p] = MAX_LEN;
            dst = LISTEN_PORT;
        end
        pkt_data[p][0] = src[15:8];
        pkt_data[p][1] = src[7:0];
        pkt_data[p][2] = dst[15:8];
        pkt_data[p][3] = dst[7:0];
        for (i = 4; i < MAX_LEN; i++) begin
            pkt_data[p][i] = byte_t'($random(seed));
        end
        total_bytes += pkt_len[p];
    end
endtask

task automatic send_packet(input int idx);
    int    i;
    beat_t b;
    logic  took;
    for (i = 0; i < pkt_len[idx]; i++) begin
        while (($random(seed) & 3) == 0) begin
            i_in_valid = 1'b0;
            @(posedge i_clk);
            #1;
        end
        b.data = pkt_data[idx][i];
        b.last = (i == pkt_len[idx] - 1);
        i_in       = b;
        i_in_valid = 1'b1;
        if (i == 0) begin
            i_hdr_valid  = 1'b1;
            i_hdr.src_ip = pkt_ip[idx];
            i_hdr.length = 16'(40 + pkt_len[idx]);
        end
        took = 1'b0;
        while (!took) begin
            @(negedge i_clk);
            took = o_in_ready;
            @(posedge i_clk);
            #1;
        end
        i_hdr_valid = 1'b0;
    end
    i_in_valid = 1'b0;
endtask

always @(posedge i_clk) begin
    #1;
    i_out_ready = (($random(ready_seed) % 3) != 0);
end

always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
        $display("timeout after %0d cycles, the DUT stopped delivering packets", cycle_count);
        $display("Simulation failed");
        $finish;
    end
end

// outputs are settled at the falling edge, the transfer follows on the rising one
always @(negedge i_clk) begin
    if (!i_rst && o_out_valid && i_out_ready) begin
        if (exp_beats.size() == 0) begin
            $display("output beat %h arrived when no more data was expected", o_out);
            beat_errs++;
        end else begin
            mon_beat = exp_beats.pop_front();
            mon_pkt  = exp_beat_pkt.pop_front();
            beat_checks++;
            if (o_out !== mon_beat) begin
                $display("ERROR payload_stream pkt %0d: expected %h, actual %h",
                         mon_pkt, mon_beat, o_out);
                beat_errs++;
            end
        end
    end
    if (!i_rst && o_meta_valid) begin
        if (exp_metas.size() == 0) begin
            $display("metadata pulse seen when no forwarded packet was expected");
            meta_errs++;
        end else begin
            mon_meta  = exp_metas.pop_front();
            mon_pkt   = exp_meta_pkt.pop_front();
            mon_drops = exp_meta_drops.pop_front();
            meta_checks++;
            drop_checks++;
            if (o_meta !== mon_meta) begin
                $display("ERROR metadata pkt %0d: expected %h, actual %h",
                         mon_pkt, mon_meta, o_meta);
                meta_errs++;
            end
            if (o_drop_count !== drop_count_t'(mon_drops)) begin
                $display("ERROR drop_count pkt %0d: expected %0d, actual %0d",
                         mon_pkt, mon_drops, o_drop_count);
                drop_errs++;
            end
        end
    end
end

initial begin
    int p;
    int total_checks;
    int total_errs;
    i_clk         = 1'b0;
    i_rst         = 1'b1;
    i_hdr_valid   = 1'b0;
    i_hdr         = '0;
    i_in_valid    = 1'b0;
    i_in          = '0;
    i_out_ready   = 1'b0;
    i_listen_port = LISTEN_PORT;
    seed          = SEED;
    ready_seed    = SEED + 1;
    cycle_count   = 0;
    cycle_limit   = 0;
    ref_drops     = 0;
    reset_checks  = 0;
    reset_errs    = 0;
    beat_checks   = 0;
    beat_errs     = 0;
    meta_checks   = 0;
    meta_errs     = 0;
    drop_checks   = 0;
    drop_errs     = 0;

    build_packets();
    for (p = 0; p < NUM_PKTS; p++) begin
        predict_packet(p);
    end
    cycle_limit = 4 * total_bytes + 20 * NUM_PKTS + 200;

    repeat (5) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    reset_checks += 4;
    if (o_out_valid !== 1'b0) begin
        $display("ERROR reset_state o_out_valid: expected 0, actual %b", o_out_valid);
        reset_errs++;
    end
    if (o_meta_valid !== 1'b0) begin
        $display("ERROR reset_state o_meta_valid: expected 0, actual %b", o_meta_valid);
        reset_errs++;
    end
    if (o_drop_count !== '0) begin
        $display("ERROR reset_state o_drop_count: expected 0, actual %0d", o_drop_count);
        reset_errs++;
    end
    if (o_in_ready !== 1'b0) begin
        $display("ERROR reset_state o_in_ready: expected 0, actual %b", o_in_ready);
        reset_errs++;
    end
    @(posedge i_clk);
    #1;
    reset_checks++;
    if (o_in_ready !== 1'b1) begin
        $display("ERROR reset_state o_in_ready after release: expected 1, actual %b",
                 o_in_ready);
        reset_errs++;
    end
    $display("test reset_state: %0d checks, %0d errors", reset_checks, reset_errs);

    for (p = 0; p < NUM_PKTS; p++) begin
        send_packet(p);
    end
    while (exp_beats.size() != 0 || exp_metas.size() != 0) begin
        @(posedge i_clk);
    end
    #1;
    $display("test payload_stream: %0d checks, %0d errors", beat_checks, beat_errs);
    $display("test metadata: %0d checks, %0d errors", meta_checks, meta_errs);

    drop_checks++;
    if (o_drop_count !== drop_count_t'(ref_drops)) begin
        $display("ERROR drop_count final: expected %0d, actual %0d", ref_drops, o_drop_count);
        drop_errs++;
    end
    $display("test drop_count: %0d checks, %0d errors", drop_checks, drop_errs);

    total_checks = reset_checks + beat_checks + meta_checks + drop_checks;
    total_errs   = reset_errs + beat_errs + meta_errs + drop_errs;
    $display("%0d packets, %0d checks, %0d errors", NUM_PKTS, total_checks, total_errs);
    if (total_errs == 0) begin
        $display("Simulation passed");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
rtl/tcp_rx_pkg.sv
rtl/skid_buffer.sv
rtl/tcp_dest_decap.sv
rtl/payload_fifo.sv
rtl/port_filter.sv
rtl/tcp_rx_top.sv
bench/tb_tcp_rx.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tcp_rx
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
EXE       ?= V$(TOP)
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(EXE)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/$(EXE))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
